//--- Makefile
VERILATOR ?= verilator
TOP ?= clique_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/clique_pkg.sv
package clique_pkg;

	localparam int MAX_VERTS = 32;
	localparam int VERT_BITS = 5;
	localparam int SIZE_BITS = 6;
	localparam int NUM_ENGINES = 2;
	localparam int ENG_BITS = 1;

	typedef struct packed {
		logic [VERT_BITS-1:0] vertex;
		logic [MAX_VERTS-1:0] data;
	} row_write_t;

	typedef struct packed {
		logic [SIZE_BITS-1:0] size;
		logic [VERT_BITS-1:0] root;
		logic [MAX_VERTS-1:0] members;
	} clique_report_t;

	typedef struct packed {
		logic [ENG_BITS-1:0] eng;
		logic [MAX_VERTS-1:0] row;
	} row_resp_t;

	typedef enum logic [2:0] {
		E_IDLE,
		E_FETCH_ROOT,
		E_EXPAND,
		E_FETCH_ROW,
		E_REPORT,
		E_POP
	} engine_state_e;

	typedef enum logic [1:0] {
		D_IDLE,
		D_RUN,
		D_FINISH
	} dispatch_state_e;

	// Index of the lowest set bit, zero for an empty mask.
	function automatic logic [VERT_BITS-1:0] first_set(input logic [MAX_VERTS-1:0] mask);
		logic [VERT_BITS-1:0] idx;
		idx = '0;
		for (int i = MAX_VERTS - 1; i >= 0; i--) begin
			if (mask[i]) begin
				idx = VERT_BITS'(i);
			end
		end
		return idx;
	endfunction

endpackage

//--- filelist.f
common/clique_pkg.sv
matrix_store/adjacency_ram.sv
matrix_store/row_arbiter.sv
logic/clique_engine.sv
logic/root_dispatcher.sv
logic/clique_top.sv
tests/clique_sva.sv
tests/clique_tb.sv

//--- logic/clique_engine.sv
`timescale 1ns/1ps

module clique_engine #(
	parameter int ENG_ID = 0
) (
	input  logic                              i_clk,
	input  logic                              i_reset,
	input  logic                              i_start_stb,
	input  logic [clique_pkg::VERT_BITS-1:0]  i_root,
	input  logic [clique_pkg::SIZE_BITS-1:0]  i_n_vertices,
	input  logic [clique_pkg::SIZE_BITS-1:0]  i_best_size,
	output logic                              o_idle,
	output logic                              o_row_req,
	output logic [clique_pkg::VERT_BITS-1:0]  o_row_vertex,
	input  logic                              i_grant,
	input  logic                              i_resp_valid,
	input  clique_pkg::row_resp_t             i_resp,
	output logic                              o_report_stb,
	output clique_pkg::clique_report_t        o_report
);
	import clique_pkg::*;

	engine_state_e state;

	// Search stack, one entry per depth below the root.
	logic [MAX_VERTS-1:0] cand [MAX_VERTS];
	logic [VERT_BITS-1:0] chosen [MAX_VERTS];

	logic [MAX_VERTS-1:0] members;
	logic [SIZE_BITS-1:0] size;
	logic [VERT_BITS-1:0] depth;
	logic [VERT_BITS-1:0] root;
	logic [SIZE_BITS-1:0] n_verts;

	logic [MAX_VERTS-1:0] cur_cand;
	logic [VERT_BITS-1:0] next_vert;
	logic [SIZE_BITS:0] bound;
	logic can_grow;
	logic resp_hit;
	logic [MAX_VERTS-1:0] above_mask;
	logic [MAX_VERTS-1:0] limit_mask;

	assign cur_cand = cand[depth];
	assign next_vert = first_set(cur_cand);
	assign bound = (SIZE_BITS+1)'(size) + (SIZE_BITS+1)'($countones(cur_cand));
	assign can_grow = bound > (SIZE_BITS+1)'(i_best_size); // Else this branch cannot win.
	assign resp_hit = i_resp_valid && (i_resp.eng == ENG_BITS'(ENG_ID));

	// Only vertices above the root, so each clique is found from its lowest member.
	assign above_mask = {MAX_VERTS{1'b1}} << (32'(root) + 32'd1);
	assign limit_mask = (n_verts >= SIZE_BITS'(MAX_VERTS)) ? '1 :
		((MAX_VERTS'(1) << n_verts) - MAX_VERTS'(1));

	assign o_idle = (state == E_IDLE);
	assign o_report_stb = (state == E_REPORT);
	assign o_report = '{size: size, root: root, members: members};

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			state <= E_IDLE;
			o_row_req <= 1'b0;
			depth <= '0;
		end else begin
			if (i_grant) begin
				o_row_req <= 1'b0;
			end
			case (state)
				E_IDLE: begin
					if (i_start_stb) begin
						o_row_req <= 1'b1;
						state <= E_FETCH_ROOT;
					end
				end
				E_FETCH_ROOT: begin
					if (resp_hit) begin
						depth <= '0;
						state <= E_EXPAND;
					end
				end
				E_EXPAND: begin
					if (!can_grow) begin
						state <= E_POP;
					end else if (cur_cand == '0) begin
						state <= E_REPORT; // A leaf that beats the best.
					end else begin
						o_row_req <= 1'b1;
						state <= E_FETCH_ROW;
					end
				end
				E_FETCH_ROW: begin
					if (resp_hit) begin
						depth <= depth + 1'b1;
						state <= E_EXPAND;
					end
				end
				E_REPORT: begin
					state <= E_POP;
				end
				E_POP: begin
					if (depth == '0) begin
						state <= E_IDLE;
					end else begin
						depth <= depth - 1'b1;
						state <= E_EXPAND;
					end
				end
				default: begin
					state <= E_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		case (state)
			E_IDLE: begin
				if (i_start_stb) begin
					root <= i_root;
					n_verts <= i_n_vertices;
					o_row_vertex <= i_root;
				end
			end
			E_FETCH_ROOT: begin
				if (resp_hit) begin
					cand[0] <= i_resp.row & above_mask & limit_mask;
					members <= MAX_VERTS'(1) << root;
					size <= SIZE_BITS'(1);
				end
			end
			E_EXPAND: begin
				if (can_grow && cur_cand != '0) begin
					cand[depth] <= cur_cand & ~(MAX_VERTS'(1) << next_vert);
					chosen[depth] <= next_vert;
					o_row_vertex <= next_vert;
				end
			end
			E_FETCH_ROW: begin
				if (resp_hit) begin
					cand[depth + 1'b1] <= cur_cand & i_resp.row;
					members <= members | (MAX_VERTS'(1) << chosen[depth]);
					size <= size + 1'b1;
				end
			end
			E_POP: begin
				if (depth != '0) begin
					members <= members & ~(MAX_VERTS'(1) << chosen[depth - 1'b1]);
					size <= size - 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

//--- logic/clique_top.sv
`timescale 1ns/1ps

module clique_top (
	input  logic                             i_clk,
	input  logic                             i_reset,
	input  logic                             i_go,
	input  logic [clique_pkg::SIZE_BITS-1:0] i_n_vertices,
	input  logic [clique_pkg::SIZE_BITS-1:0] i_init_maxsize,
	input  logic                             i_matrix_wr_stb,
	input  clique_pkg::row_write_t           i_matrix_wr,
	output logic                             o_clq_valid,
	output clique_pkg::clique_report_t       o_clq,
	output logic [clique_pkg::SIZE_BITS-1:0] o_max_size,
	output logic                             o_done,
	output logic                             o_busy
);
	import clique_pkg::*;

	logic [NUM_ENGINES-1:0] engine_idle;
	logic [NUM_ENGINES-1:0] report_stb;
	clique_report_t report [NUM_ENGINES];
	logic [NUM_ENGINES-1:0] start_stb;
	logic [VERT_BITS-1:0] start_root;
	logic [SIZE_BITS-1:0] n_vertices;
	logic [SIZE_BITS-1:0] best_size;
	logic write_enable;

	logic [NUM_ENGINES-1:0] row_req;
	logic [VERT_BITS-1:0] row_vertex [NUM_ENGINES];
	logic [NUM_ENGINES-1:0] grant;
	logic resp_valid;
	row_resp_t resp;

	assign o_max_size = best_size;

	root_dispatcher root_dispatcher_inst (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_go           (i_go),
		.i_n_vertices   (i_n_vertices),
		.i_init_maxsize (i_init_maxsize),
		.i_engine_idle  (engine_idle),
		.i_report_stb   (report_stb),
		.i_report       (report),
		.o_start_stb    (start_stb),
		.o_root         (start_root),
		.o_n_vertices   (n_vertices),
		.o_best_size    (best_size),
		.o_clq_valid    (o_clq_valid),
		.o_clq          (o_clq),
		.o_done         (o_done),
		.o_busy         (o_busy),
		.o_write_enable (write_enable)
	);

	// Responses go to every engine, each one picks out its own tag.
	for (genvar g = 0; g < NUM_ENGINES; g++) begin : g_engine
		clique_engine #(
			.ENG_ID (g)
		) clique_engine_inst (
			.i_clk        (i_clk),
			.i_reset      (i_reset),
			.i_start_stb  (start_stb[g]),
			.i_root       (start_root),
			.i_n_vertices (n_vertices),
			.i_best_size  (best_size),
			.o_idle       (engine_idle[g]),
			.o_row_req    (row_req[g]),
			.o_row_vertex (row_vertex[g]),
			.i_grant      (grant[g]),
			.i_resp_valid (resp_valid),
			.i_resp       (resp),
			.o_report_stb (report_stb[g]),
			.o_report     (report[g])
		);
	end

	row_arbiter row_arbiter_inst (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_wr_stb     (i_matrix_wr_stb),
		.i_wr_enable  (write_enable),
		.i_wr         (i_matrix_wr),
		.i_req        (row_req),
		.i_req_vertex (row_vertex),
		.o_grant      (grant),
		.o_resp_valid (resp_valid),
		.o_resp       (resp)
	);

endmodule

//--- logic/root_dispatcher.sv
`timescale 1ns/1ps

module root_dispatcher (
	input  logic                               i_clk,
	input  logic                               i_reset,
	input  logic                               i_go,
	input  logic [clique_pkg::SIZE_BITS-1:0]   i_n_vertices,
	input  logic [clique_pkg::SIZE_BITS-1:0]   i_init_maxsize,
	input  logic [clique_pkg::NUM_ENGINES-1:0] i_engine_idle,
	input  logic [clique_pkg::NUM_ENGINES-1:0] i_report_stb,
	input  clique_pkg::clique_report_t         i_report [clique_pkg::NUM_ENGINES],
	output logic [clique_pkg::NUM_ENGINES-1:0] o_start_stb,
	output logic [clique_pkg::VERT_BITS-1:0]   o_root,
	output logic [clique_pkg::SIZE_BITS-1:0]   o_n_vertices,
	output logic [clique_pkg::SIZE_BITS-1:0]   o_best_size,
	output logic                               o_clq_valid,
	output clique_pkg::clique_report_t         o_clq,
	output logic                               o_done,
	output logic                               o_busy,
	output logic                               o_write_enable
);
	import clique_pkg::*;

	dispatch_state_e state;
	logic [SIZE_BITS-1:0] next_root;
	logic [SIZE_BITS-1:0] best;

	logic [NUM_ENGINES-1:0] pend_valid;
	clique_report_t pend_report [NUM_ENGINES];
	logic [NUM_ENGINES-1:0] cand_valid;
	clique_report_t cand_report [NUM_ENGINES];

	logic [ENG_BITS-1:0] win;
	logic [NUM_ENGINES-1:0] free_eng;
	logic [ENG_BITS-1:0] free_sel;
	logic do_start;
	logic all_quiet;

	// A report that lost arbitration last cycle is checked again.
	always_comb begin
		for (int e = 0; e < NUM_ENGINES; e++) begin
			cand_valid[e] = pend_valid[e] | i_report_stb[e];
			cand_report[e] = pend_valid[e] ? pend_report[e] : i_report[e];
		end
	end

	assign win = ENG_BITS'(first_set(MAX_VERTS'(cand_valid)));
	assign free_eng = i_engine_idle & ~o_start_stb; // A just-started engine still looks idle.
	assign free_sel = ENG_BITS'(first_set(MAX_VERTS'(free_eng)));
	assign do_start = (state == D_RUN) && (next_root < o_n_vertices) && (free_eng != '0);
	assign all_quiet = (next_root >= o_n_vertices) && (o_start_stb == '0) &&
		(&i_engine_idle) && (cand_valid == '0);

	assign o_best_size = best;
	assign o_done = (state == D_FINISH);
	assign o_busy = (state == D_RUN);
	assign o_write_enable = (state == D_IDLE);

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			state <= D_IDLE;
			next_root <= '0;
			best <= '0;
			pend_valid <= '0;
			o_start_stb <= '0;
			o_clq_valid <= 1'b0;
		end else begin
			o_start_stb <= '0;
			o_clq_valid <= 1'b0;
			for (int e = 0; e < NUM_ENGINES; e++) begin
				pend_valid[e] <= cand_valid[e] && (ENG_BITS'(e) != win);
			end
			if (cand_valid != '0 && cand_report[win].size > best) begin
				o_clq_valid <= 1'b1;
				best <= cand_report[win].size;
			end
			if (do_start) begin
				o_start_stb[free_sel] <= 1'b1;
				next_root <= next_root + 1'b1;
			end
			case (state)
				D_IDLE: begin
					if (i_go) begin
						best <= i_init_maxsize;
						next_root <= '0;
						state <= D_RUN;
					end
				end
				D_RUN: begin
					if (all_quiet) begin
						state <= D_FINISH;
					end
				end
				default: begin
					state <= D_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		o_clq <= cand_report[win];
		for (int e = 0; e < NUM_ENGINES; e++) begin
			pend_report[e] <= cand_report[e];
		end
		if (do_start) begin
			o_root <= next_root[VERT_BITS-1:0];
		end
		if (state == D_IDLE && i_go) begin
			o_n_vertices <= i_n_vertices;
		end
	end

endmodule

//--- matrix_store/adjacency_ram.sv
`timescale 1ns/1ps

module adjacency_ram (
	input  logic                              i_clk,
	input  logic                              i_reset,
	input  logic                              i_wr_stb,
	input  clique_pkg::row_write_t            i_wr,
	input  logic                              i_rd_stb,
	input  logic [clique_pkg::VERT_BITS-1:0]  i_rd_vertex,
	output logic [clique_pkg::MAX_VERTS-1:0]  o_rd_data
);
	import clique_pkg::*;

	logic [MAX_VERTS-1:0] rows [MAX_VERTS];

	// One full row per vertex, bit j of row i set when i and j are adjacent.
	always_ff @(posedge i_clk) begin
		if (i_wr_stb) begin
			rows[i_wr.vertex] <= i_wr.data;
		end
	end

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			o_rd_data <= '0;
		end else if (i_rd_stb) begin
			o_rd_data <= rows[i_rd_vertex]; // Row is valid on the next cycle.
		end
	end

endmodule

//--- matrix_store/row_arbiter.sv
`timescale 1ns/1ps

module row_arbiter (
	input  logic                              i_clk,
	input  logic                              i_reset,
	input  logic                              i_wr_stb,
	input  logic                              i_wr_enable,
	input  clique_pkg::row_write_t            i_wr,
	input  logic [clique_pkg::NUM_ENGINES-1:0] i_req,
	input  logic [clique_pkg::VERT_BITS-1:0]  i_req_vertex [clique_pkg::NUM_ENGINES],
	output logic [clique_pkg::NUM_ENGINES-1:0] o_grant,
	output logic                              o_resp_valid,
	output clique_pkg::row_resp_t             o_resp
);
	import clique_pkg::*;

	logic [ENG_BITS-1:0] rr_ptr;
	logic [ENG_BITS-1:0] sel;
	logic [ENG_BITS-1:0] resp_tag;
	logic sel_valid;
	logic [MAX_VERTS-1:0] rd_data;

	// Scan from the pointer onwards so the engine after the last winner goes first.
	always_comb begin
		int idx;
		sel = rr_ptr;
		sel_valid = 1'b0;
		for (int k = NUM_ENGINES - 1; k >= 0; k--) begin
			idx = (int'(rr_ptr) + k) % NUM_ENGINES;
			if (i_req[idx]) begin
				sel = ENG_BITS'(idx);
				sel_valid = 1'b1;
			end
		end
	end

	assign o_grant = sel_valid ? (NUM_ENGINES'(1) << sel) : '0;

	always_ff @(posedge i_clk or posedge i_reset) begin
		if (i_reset) begin
			rr_ptr <= '0;
			o_resp_valid <= 1'b0;
		end else begin
			o_resp_valid <= sel_valid;
			if (sel_valid) begin
				rr_ptr <= (sel == ENG_BITS'(NUM_ENGINES - 1)) ? '0 : sel + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (sel_valid) begin
			resp_tag <= sel; // Follows the row through the RAM read.
		end
	end

	assign o_resp = '{eng: resp_tag, row: rd_data};

	adjacency_ram adjacency_ram_inst (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_wr_stb    (i_wr_stb & i_wr_enable), // Writes only land between searches.
		.i_wr        (i_wr),
		.i_rd_stb    (sel_valid),
		.i_rd_vertex (i_req_vertex[sel]),
		.o_rd_data   (rd_data)
	);

endmodule

//--- tests/clique_sva.sv
`timescale 1ns/1ps

module clique_sva (
	input logic                       i_clk,
	input logic                       i_reset,
	input logic                       i_start_stb,
	input logic                       o_idle,
	input logic                       o_row_req,
	input logic                       i_grant,
	input logic                       o_report_stb,
	input clique_pkg::clique_report_t o_report
);

	// The arbiter serializes the engines, so a request must wait for its grant.
	a_req_held: assert property (@(posedge i_clk) disable iff (i_reset)
		o_row_req && !i_grant |=> o_row_req)
		else $error("row request dropped before its grant");

	// Members and size are kept apart in the engine, so they must agree at a report.
	a_report_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		o_report_stb |-> !o_idle && o_report.members[o_report.root] &&
			($countones(o_report.members) == int'(o_report.size)))
		else $error("clique report from an idle engine or with a bad member mask");

	a_start_idle: assert property (@(posedge i_clk) disable iff (i_reset)
		i_start_stb |-> o_idle)
		else $error("start strobe to an engine that is still searching");

endmodule

bind clique_engine clique_sva clique_sva_inst (
	.i_clk        (i_clk),
	.i_reset      (i_reset),
	.i_start_stb  (i_start_stb),
	.o_idle       (o_idle),
	.o_row_req    (o_row_req),
	.i_grant      (i_grant),
	.o_report_stb (o_report_stb),
	.o_report     (o_report)
);

//--- tests/clique_tb.sv
`timescale 1ns/1ps

module clique_tb;
	import clique_pkg::*;

	localparam int TIMEOUT_CYCLES = 500000;

	logic i_clk;
	logic i_reset;
	logic i_go;
	logic [SIZE_BITS-1:0] i_n_vertices;
	logic [SIZE_BITS-1:0] i_init_maxsize;
	logic i_matrix_wr_stb;
	row_write_t i_matrix_wr;
	logic o_clq_valid;
	clique_report_t o_clq;
	logic [SIZE_BITS-1:0] o_max_size;
	logic o_done;
	logic o_busy;

	logic [MAX_VERTS-1:0] adj [MAX_VERTS]; // Graph as the host last loaded it.
	clique_report_t reports [$];
	logic [SIZE_BITS-1:0] last_size;
	int search_n;
	int errors;
	int checks;
	int seed;
	logic timed_out;

	clique_top clique_top_inst (
		.i_clk           (i_clk),
		.i_reset         (i_reset),
		.i_go            (i_go),
		.i_n_vertices    (i_n_vertices),
		.i_init_maxsize  (i_init_maxsize),
		.i_matrix_wr_stb (i_matrix_wr_stb),
		.i_matrix_wr     (i_matrix_wr),
		.o_clq_valid     (o_clq_valid),
		.o_clq           (o_clq),
		.o_max_size      (o_max_size),
		.o_done          (o_done),
		.o_busy          (o_busy)
	);

	always #5 i_clk = ~i_clk;

	task automatic next_cycle();
		@(posedge i_clk);
		#1;
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("At %0t: %s", $time, what);
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		if (cond !== 1'b1) begin
			report_failure(what);
		end
	endtask

	task automatic check_size(input string name, input logic [SIZE_BITS-1:0] got,
		input logic [SIZE_BITS-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_report(input string name, input clique_report_t got,
		input clique_report_t exp);
		check_size({name, ".size"}, got.size, exp.size);
		checks++;
		if (got.root !== exp.root) begin
			errors++;
			$display("ERROR t=%0t %s.root: got %0d, expected %0d", $time, name, got.root, exp.root);
		end
		checks++;
		if (got.members !== exp.members) begin
			errors++;
			$display("ERROR t=%0t %s.members: got %h, expected %h", $time, name,
				got.members, exp.members);
		end
	endtask

	function automatic logic is_clique(input logic [MAX_VERTS-1:0] mask);
		logic ok;
		logic [MAX_VERTS-1:0] row;
		ok = 1'b1;
		for (int v = 0; v < MAX_VERTS; v++) begin
			row = adj[v] | (MAX_VERTS'(1) << v);
			if (mask[v] && ((row & mask) != mask)) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	// Tries every vertex subset, so keep n small.
	function automatic int ref_max_clique(input int n);
		int best;
		int cnt;
		best = 0;
		for (int k = 1; k < (1 << n); k++) begin
			cnt = $countones(MAX_VERTS'(k));
			if (cnt > best && is_clique(MAX_VERTS'(k))) begin
				best = cnt;
			end
		end
		return best;
	endfunction

	function automatic int random_below(input int limit);
		return int'({$random(seed)} % limit);
	endfunction

	task automatic clear_graph();
		for (int v = 0; v < MAX_VERTS; v++) begin
			adj[v] = '0;
		end
	endtask

	task automatic add_edge(input int a, input int b);
		adj[a] = adj[a] | (MAX_VERTS'(1) << b);
		adj[b] = adj[b] | (MAX_VERTS'(1) << a);
	endtask

	task automatic load_graph();
		for (int v = 0; v < MAX_VERTS; v++) begin
			i_matrix_wr_stb = 1'b1;
			i_matrix_wr.vertex = VERT_BITS'(v);
			i_matrix_wr.data = adj[v];
			next_cycle();
		end
		i_matrix_wr_stb = 1'b0;
	endtask

	// Rows 0 to 3 would connect to every vertex if the writes were accepted.
	task automatic write_during_search(input int n);
		for (int v = 0; v < 4; v++) begin
			check_true(o_busy, "matrix write was not issued during a search");
			i_matrix_wr_stb = 1'b1;
			i_matrix_wr.vertex = VERT_BITS'(v);
			i_matrix_wr.data = ((MAX_VERTS'(1) << n) - MAX_VERTS'(1)) & ~(MAX_VERTS'(1) << v);
			next_cycle();
		end
		i_matrix_wr_stb = 1'b0;
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		@(negedge i_clk);
		while (!o_done && cycles < TIMEOUT_CYCLES) begin
			if (!o_busy) begin
				report_failure("o_busy fell before o_done");
			end
			cycles++;
			@(negedge i_clk);
		end
		if (!o_done) begin
			timed_out = 1'b1;
			report_failure("o_done did not arrive before the timeout");
		end else begin
			check_true(!o_busy, "o_busy still high in the o_done cycle");
			@(negedge i_clk);
			check_true(!o_done, "o_done lasted more than one cycle");
		end
		next_cycle();
	endtask

	task automatic run_search(input int n, input int init, input int expect_max,
		input logic disturb);
		if (!timed_out) begin
			reports.delete();
			search_n = n;
			last_size = SIZE_BITS'(init);
			i_go = 1'b1;
			i_n_vertices = SIZE_BITS'(n);
			i_init_maxsize = SIZE_BITS'(init);
			next_cycle();
			i_go = 1'b0;
			if (disturb) begin
				write_during_search(n);
			end
			wait_done();
			check_size("o_max_size", o_max_size, SIZE_BITS'(expect_max));
			if (expect_max > init) begin
				check_true(reports.size() > 0, "no clique was reported");
			end else begin
				check_true(reports.size() == 0, "a clique at or below the bound was reported");
			end
		end
	endtask

	// Every report must be a real clique found from its lowest member.
	always @(negedge i_clk) begin
		if (!i_reset && o_clq_valid) begin
			reports.push_back(o_clq);
			check_size("o_clq.size", o_clq.size, SIZE_BITS'($countones(o_clq.members)));
			check_true(is_clique(o_clq.members), "reported member mask is not a clique");
			check_true(o_clq.members[o_clq.root], "reported root is not a member");
			check_true((o_clq.members & ((MAX_VERTS'(1) << o_clq.root) - MAX_VERTS'(1))) == '0,
				"reported root is not the lowest member");
			check_true((o_clq.members >> search_n) == '0, "member beyond the vertex count");
			check_true(o_clq.size > last_size, "report size did not rise above the best");
			last_size = o_clq.size;
		end
	end

	initial begin
		int n;
		int ones_seen;
		clique_report_t exp_rep;
		i_clk = 1'b0;
		i_reset = 1'b1;
		i_go = 1'b0;
		i_n_vertices = '0;
		i_init_maxsize = '0;
		i_matrix_wr_stb = 1'b0;
		i_matrix_wr = '0;
		errors = 0;
		checks = 0;
		seed = 32'hb0a4;
		timed_out = 1'b0;
		search_n = 0;
		last_size = '0;
		clear_graph();
		repeat (8) @(posedge i_clk);
		#1;
		i_reset = 1'b0;
		check_true(!o_busy && !o_done && !o_clq_valid, "outputs not low after reset");
		next_cycle();

		// 12 vertices on a ring, with a 5-clique on the even vertices 2 to 10.
		clear_graph();
		for (int i = 0; i < 12; i++) begin
			add_edge(i, (i + 1) % 12);
		end
		for (int i = 0; i < 5; i++) begin
			for (int j = i + 1; j < 5; j++) begin
				add_edge(2 * i + 2, 2 * j + 2);
			end
		end
		load_graph();
		check_size("reference maximum", SIZE_BITS'(ref_max_clique(12)), SIZE_BITS'(5));
		run_search(12, 0, ref_max_clique(12), 1'b0);
		run_search(12, 5, 5, 1'b0);
		run_search(12, 9, 9, 1'b0);
		run_search(12, 0, ref_max_clique(12), 1'b1);

		clear_graph();
		for (int i = 0; i < 10; i++) begin
			add_edge(i, (i + 1) % 10);
		end
		load_graph();
		run_search(10, 0, ref_max_clique(10), 1'b0);

		clear_graph();
		load_graph();
		run_search(1, 0, ref_max_clique(1), 1'b0);
		exp_rep.size = SIZE_BITS'(1);
		exp_rep.root = '0;
		exp_rep.members = MAX_VERTS'(1);
		check_true(reports.size() == 1, "empty graph did not give exactly one report");
		if (reports.size() > 0) begin
			check_report("o_clq", reports[0], exp_rep);
		end

		for (int v = 0; v < MAX_VERTS; v++) begin
			adj[v] = ~(MAX_VERTS'(1) << v);
		end
		load_graph();
		run_search(MAX_VERTS, 0, MAX_VERTS, 1'b0);
		exp_rep.size = SIZE_BITS'(MAX_VERTS);
		exp_rep.members = '1;
		ones_seen = 0;
		foreach (reports[i]) begin
			if (reports[i].members == '1) begin
				ones_seen++;
			end
		end
		check_true(ones_seen == 1, "full clique mask was not reported exactly once");
		if (reports.size() > 0) begin
			check_report("last o_clq", reports[reports.size() - 1], exp_rep);
		end

		for (int g = 0; g < 6; g++) begin
			clear_graph();
			n = 8 + random_below(9);
			for (int i = 0; i < n; i++) begin
				for (int j = i + 1; j < n; j++) begin
					if (random_below(8) < 5) begin
						add_edge(i, j);
					end
				end
			end
			load_graph();
			run_search(n, 0, ref_max_clique(n), 1'b0);
		end

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
